// ==== src/jtcop_sdram_pkg.sv ====
package jtcop_sdram_pkg;

    // SDRAM word offsets inside bank 0
    localparam logic [21:0] rom_offset = 22'h00_0000;
    localparam logic [21:0] ram_offset = 22'h04_0000;

    // B0 tile map starts 16 kB into the RAM region
    localparam logic [21:0] b0_offset  = 22'h00_2000;

    // First downloaded byte that belongs to bank 1
    localparam logic [24:0] ba1_start  = 25'h08_0000;

    localparam int vram_aw = 15;
    localparam int rom_aw  = 18;
    localparam int b0_aw   = 13;

    // Hold-off after the download ends
    localparam logic [7:0] settle_cycles = 8'd64;

    // Scan order of the round robin follows the encoding
    typedef enum logic [1:0] {
        slot_prog,
        slot_ram,
        slot_rom,
        slot_b0
    } slot_e;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack,
        st_wait_dst,
        st_wait_rdy
    } arb_state_e;

endpackage

// ==== src/jtcop_vram_map.sv ====
`timescale 1ns/100ps

module jtcop_vram_map(
    input        [12:0] ram_addr,
    input               fsft_cs,
    input               fmap_cs,
    input               bsft_cs,
    input               bmap_cs,
    input               csft_cs,
    input               cmap_cs,
    output logic [jtcop_sdram_pkg::vram_aw-1:0] ram_maddr
);

// 40 kB RAM seen as 20k words
// 0000-1FFF  CPU work RAM
// 2000-3FFF  first layer, shift then map
// 4000-47FF  second layer
// 4800-4FFF  third layer

always_comb begin
    ram_maddr = {2'b00, ram_addr};
    // First layer windows are 4k words each
    if (fsft_cs) begin
        ram_maddr[14:12] = 3'b010;
    end else if (fmap_cs) begin
        ram_maddr[14:12] = 3'b011;
    // The other two only get 1k words per window
    end else if (bsft_cs) begin
        ram_maddr[14:10] = 5'b1_0000;
    end else if (bmap_cs) begin
        ram_maddr[14:10] = 5'b1_0001;
    end else if (csft_cs) begin
        ram_maddr[14:10] = 5'b1_0010;
    end else if (cmap_cs) begin
        ram_maddr[14:10] = 5'b1_0011;
    end
end

endmodule

// ==== src/jtcop_slot_cache.sv ====
`timescale 1ns/100ps

module jtcop_slot_cache #(
    parameter int aw = 15,
    parameter int dw = 16
)(
    input             rst,
    input             clk,
    input             flush,
    input             cs,
    input    [aw-1:0] addr,
    input             wen,
    input    [15:0]   din,
    input    [ 1:0]   wrmask,
    input             grant,
    input             ba_rdy,
    input    [15:0]   data_read,
    output            req,
    output            req_wr,
    output   [dw-1:0] dout,
    output            ok
);

logic [aw-1:0] addr_q;
logic [15:0]   data_q;
logic          valid;
logic          done;
logic          ok_q;
logic          match;
logic          good;
logic          finish;

assign match  = addr_q == addr;
// A write is served once it went out, a read once the word is held
assign good   = match & (wen ? done : valid);
assign finish = grant & ba_rdy;
assign req    = cs & ~good;
assign req_wr = cs & wen;
assign dout   = data_q[dw-1:0];
// Address compare keeps ok combinational on a change
assign ok     = ok_q & good;

always_ff @(posedge clk) begin
    if (rst) begin
        valid <= 1'b0;
        done  <= 1'b0;
        ok_q  <= 1'b0;
    end else begin
        ok_q <= cs & ~flush & (good | finish);
        if (flush) begin
            valid <= 1'b0;
            done  <= 1'b0;
        end else if (finish) begin
            done  <= wen;
            // A partial write only stays valid if the old word was ours
            valid <= wen ? (valid & match) | (wrmask == 2'b00) : 1'b1;
        end else begin
            done <= done & cs & wen & match;
        end
    end
end

always_ff @(posedge clk) begin
    if (finish) begin
        addr_q <= addr;
        if (wen) begin
            // Mask bits are active low, bit 1 is the upper byte
            if (!wrmask[1]) begin
                data_q[15:8] <= din[15:8];
            end
            if (!wrmask[0]) begin
                data_q[7:0] <= din[7:0];
            end
        end else begin
            data_q <= data_read;
        end
    end
end

endmodule

// ==== src/jtcop_bank_fsm.sv ====
`timescale 1ns/100ps

module jtcop_bank_fsm(
    input               rst,
    input               clk,
    input               busy,
    input               req_ram,
    input               req_wr_ram,
    input               req_rom,
    input               req_b0,
    input               prog_we,
    input               ba_ack,
    input               ba_dst,
    input               ba_rdy,
    input        [21:0] addr_ram,
    input        [21:0] addr_rom,
    input        [21:0] addr_b0,
    input        [21:0] prog_addr,
    input        [15:0] din_ram,
    input        [ 1:0] mask_ram,
    input        [15:0] prog_data,
    input        [ 1:0] prog_mask,
    output logic        grant_ram,
    output logic        grant_rom,
    output logic        grant_b0,
    output logic        prog_ack,
    output              prog_rdy,
    output logic        sdram_rd,
    output logic        sdram_wr,
    output logic [21:0] sdram_addr,
    output logic [15:0] data_write,
    output logic [ 1:0] sdram_wrmask
);

import jtcop_sdram_pkg::*;

arb_state_e state;
slot_e      last;
slot_e      pick;
logic [3:0] reqs;
logic       found;
logic       pick_wr;

// Client slots stay out while the download settles
assign reqs     = {req_b0 & ~busy, req_rom & ~busy, req_ram & ~busy, prog_we};
assign prog_rdy = prog_ack & ba_rdy;
assign pick_wr  = pick == slot_prog || (pick == slot_ram && req_wr_ram);

// Round robin starting after the last slot served
always_comb begin
    pick  = last;
    found = 1'b0;
    for (int i = 1; i <= 4; i++) begin
        if (!found && reqs[2'(last + i)]) begin
            pick  = slot_e'(2'(last + i));
            found = 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        state     <= st_idle;
        last      <= slot_b0;
        grant_ram <= 1'b0;
        grant_rom <= 1'b0;
        grant_b0  <= 1'b0;
        prog_ack  <= 1'b0;
        sdram_rd  <= 1'b0;
        sdram_wr  <= 1'b0;
    end else begin
        case (state)
            st_idle: begin
                if (found) begin
                    prog_ack  <= pick == slot_prog;
                    grant_ram <= pick == slot_ram;
                    grant_rom <= pick == slot_rom;
                    grant_b0  <= pick == slot_b0;
                    sdram_wr  <= pick_wr;
                    sdram_rd  <= ~pick_wr;
                    last      <= pick;
                    state     <= st_wait_ack;
                end
            end
            st_wait_ack: begin
                if (ba_ack) begin
                    sdram_rd <= 1'b0;
                    sdram_wr <= 1'b0;
                    state    <= ba_dst ? st_wait_rdy : st_wait_dst;
                end
            end
            default: begin
                // rdy may come along with dst on short writes
                if (ba_rdy && (state == st_wait_rdy || ba_dst)) begin
                    grant_ram <= 1'b0;
                    grant_rom <= 1'b0;
                    grant_b0  <= 1'b0;
                    prog_ack  <= 1'b0;
                    state     <= st_idle;
                end else if (ba_dst) begin
                    state <= st_wait_rdy;
                end
            end
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state == st_idle && found) begin
        case (pick)
            slot_prog: begin
                sdram_addr   <= prog_addr;
                data_write   <= prog_data;
                sdram_wrmask <= prog_mask;
            end
            slot_ram: begin
                sdram_addr   <= addr_ram;
                data_write   <= din_ram;
                sdram_wrmask <= mask_ram;
            end
            slot_rom: begin
                sdram_addr   <= addr_rom;
                sdram_wrmask <= 2'b11;
            end
            default: begin
                sdram_addr   <= addr_b0;
                sdram_wrmask <= 2'b11;
            end
        endcase
    end
end

endmodule

// ==== src/jtcop_dwnld.sv ====
`timescale 1ns/100ps

module jtcop_dwnld(
    input               rst,
    input               clk,
    input               downloading,
    input        [24:0] ioctl_addr,
    input        [ 7:0] ioctl_dout,
    input               ioctl_wr,
    input               prog_ack,
    input               prog_rdy,
    output logic [21:0] prog_addr,
    output logic [15:0] prog_data,
    output logic [ 1:0] prog_mask,
    output logic        prog_we
);

import jtcop_sdram_pkg::*;

logic in_bank0;
logic new_byte;

assign in_bank0 = ioctl_addr < ba1_start;
assign new_byte = downloading & ioctl_wr & in_bank0;

always_ff @(posedge clk) begin
    if (rst) begin
        prog_we <= 1'b0;
    end else if (new_byte) begin
        prog_we <= 1'b1;
    end else if (prog_ack && prog_rdy) begin
        prog_we <= 1'b0;
    end
end

always_ff @(posedge clk) begin
    if (new_byte) begin
        prog_addr <= ioctl_addr[22:1];
        // Same byte on both lanes, the mask picks the lane
        prog_data <= {ioctl_dout, ioctl_dout};
        // Even byte goes high, active low mask
        prog_mask <= ioctl_addr[0] ? 2'b10 : 2'b01;
    end
end

endmodule

// ==== src/jtcop_busy_timer.sv ====
`timescale 1ns/100ps

module jtcop_busy_timer(
    input  rst,
    input  clk,
    input  downloading,
    output busy
);

import jtcop_sdram_pkg::*;

logic [7:0] cnt;

// Count of busy cycles still left after the download
always_ff @(posedge clk) begin
    if (rst) begin
        cnt <= 8'd0;
    end else if (downloading) begin
        cnt <= settle_cycles;
    end else if (cnt != 8'd0) begin
        cnt <= cnt - 8'd1;
    end
end

assign busy = downloading | (cnt != 8'd0);

endmodule

// ==== src/jtcop_sdram.sv ====
`timescale 1ns/100ps

module jtcop_sdram(
    input         rst,
    input         clk,

    // Main CPU
    input         ram_cs,
    input         main_cs,
    input  [jtcop_sdram_pkg::rom_aw:1] main_addr,
    input         main_rnw,
    input  [15:0] main_dout,
    input  [ 1:0] dsn,
    output [15:0] ram_data,
    output        ram_ok,
    output [15:0] main_data,
    output        main_ok,

    // Tile layer RAM windows
    input         fsft_cs,
    input         fmap_cs,
    input         bsft_cs,
    input         bmap_cs,
    input         csft_cs,
    input         cmap_cs,

    // Scroll B0 map
    input         b0_cs,
    input  [jtcop_sdram_pkg::b0_aw-1:0] b0_addr,
    output [15:0] b0_data,
    output        b0_ok,

    // SDRAM bank 0
    output [21:0] sdram_addr,
    output        sdram_rd,
    output        sdram_wr,
    output [15:0] data_write,
    output [ 1:0] sdram_wrmask,
    input         ba_ack,
    input         ba_dst,
    input         ba_rdy,
    input  [15:0] data_read,

    // ROM download
    input         downloading,
    input  [24:0] ioctl_addr,
    input  [ 7:0] ioctl_dout,
    input         ioctl_wr,
    output        dwnld_busy
);

import jtcop_sdram_pkg::*;

logic [vram_aw-1:0] ram_maddr;
logic [21:0] addr_ram;
logic [21:0] addr_rom;
logic [21:0] addr_b0;
logic        req_ram;
logic        req_wr_ram;
logic        req_rom;
logic        req_b0;
logic        grant_ram;
logic        grant_rom;
logic        grant_b0;
logic [21:0] prog_addr;
logic [15:0] prog_data;
logic [ 1:0] prog_mask;
logic        prog_we;
logic        prog_ack;
logic        prog_rdy;

// Slot addresses placed in bank 0
assign addr_ram = ram_offset + {7'd0, ram_maddr};
assign addr_rom = rom_offset + {4'd0, main_addr};
assign addr_b0  = ram_offset + b0_offset + {9'd0, b0_addr};

jtcop_vram_map u_map(
    .ram_addr   ( main_addr[13:1] ),
    .fsft_cs    ( fsft_cs         ),
    .fmap_cs    ( fmap_cs         ),
    .bsft_cs    ( bsft_cs         ),
    .bmap_cs    ( bmap_cs         ),
    .csft_cs    ( csft_cs         ),
    .cmap_cs    ( cmap_cs         ),
    .ram_maddr  ( ram_maddr       )
);

// Work RAM and video RAM, the only writable slot
jtcop_slot_cache #(.aw(vram_aw), .dw(16)) u_ram(
    .rst        ( rst        ),
    .clk        ( clk        ),
    .flush      ( dwnld_busy ),
    .cs         ( ram_cs     ),
    .addr       ( ram_maddr  ),
    .wen        ( ~main_rnw  ),
    .din        ( main_dout  ),
    .wrmask     ( dsn        ),
    .grant      ( grant_ram  ),
    .ba_rdy     ( ba_rdy     ),
    .data_read  ( data_read  ),
    .req        ( req_ram    ),
    .req_wr     ( req_wr_ram ),
    .dout       ( ram_data   ),
    .ok         ( ram_ok     )
);

jtcop_slot_cache #(.aw(rom_aw), .dw(16)) u_rom(
    .rst        ( rst        ),
    .clk        ( clk        ),
    .flush      ( dwnld_busy ),
    .cs         ( main_cs    ),
    .addr       ( main_addr  ),
    .wen        ( 1'b0       ),
    .din        ( 16'd0      ),
    .wrmask     ( 2'b11      ),
    .grant      ( grant_rom  ),
    .ba_rdy     ( ba_rdy     ),
    .data_read  ( data_read  ),
    .req        ( req_rom    ),
    .req_wr     (            ),
    .dout       ( main_data  ),
    .ok         ( main_ok    )
);

jtcop_slot_cache #(.aw(b0_aw), .dw(16)) u_b0(
    .rst        ( rst        ),
    .clk        ( clk        ),
    .flush      ( dwnld_busy ),
    .cs         ( b0_cs      ),
    .addr       ( b0_addr    ),
    .wen        ( 1'b0       ),
    .din        ( 16'd0      ),
    .wrmask     ( 2'b11      ),
    .grant      ( grant_b0   ),
    .ba_rdy     ( ba_rdy     ),
    .data_read  ( data_read  ),
    .req        ( req_b0     ),
    .req_wr     (            ),
    .dout       ( b0_data    ),
    .ok         ( b0_ok      )
);

jtcop_bank_fsm u_fsm(
    .rst          ( rst          ),
    .clk          ( clk          ),
    .busy         ( dwnld_busy   ),
    .req_ram      ( req_ram      ),
    .req_wr_ram   ( req_wr_ram   ),
    .req_rom      ( req_rom      ),
    .req_b0       ( req_b0       ),
    .prog_we      ( prog_we      ),
    .ba_ack       ( ba_ack       ),
    .ba_dst       ( ba_dst       ),
    .ba_rdy       ( ba_rdy       ),
    .addr_ram     ( addr_ram     ),
    .addr_rom     ( addr_rom     ),
    .addr_b0      ( addr_b0      ),
    .prog_addr    ( prog_addr    ),
    .din_ram      ( main_dout    ),
    .mask_ram     ( dsn          ),
    .prog_data    ( prog_data    ),
    .prog_mask    ( prog_mask    ),
    .grant_ram    ( grant_ram    ),
    .grant_rom    ( grant_rom    ),
    .grant_b0     ( grant_b0     ),
    .prog_ack     ( prog_ack     ),
    .prog_rdy     ( prog_rdy     ),
    .sdram_rd     ( sdram_rd     ),
    .sdram_wr     ( sdram_wr     ),
    .sdram_addr   ( sdram_addr   ),
    .data_write   ( data_write   ),
    .sdram_wrmask ( sdram_wrmask )
);

jtcop_dwnld u_dwnld(
    .rst          ( rst          ),
    .clk          ( clk          ),
    .downloading  ( downloading  ),
    .ioctl_addr   ( ioctl_addr   ),
    .ioctl_dout   ( ioctl_dout   ),
    .ioctl_wr     ( ioctl_wr     ),
    .prog_ack     ( prog_ack     ),
    .prog_rdy     ( prog_rdy     ),
    .prog_addr    ( prog_addr    ),
    .prog_data    ( prog_data    ),
    .prog_mask    ( prog_mask    ),
    .prog_we      ( prog_we      )
);

jtcop_busy_timer u_busy(
    .rst          ( rst          ),
    .clk          ( clk          ),
    .downloading  ( downloading  ),
    .busy         ( dwnld_busy   )
);

endmodule

// ==== testbench/sdram_model.sv ====
`timescale 1ns/100ps

module sdram_model(
    input               clk,
    input        [21:0] sdram_addr,
    input               sdram_rd,
    input               sdram_wr,
    input        [15:0] data_write,
    input        [ 1:0] sdram_wrmask,
    output logic        ba_ack,
    output logic        ba_dst,
    output logic        ba_rdy,
    output logic [15:0] data_read
);

logic [15:0] mem [int];
logic [31:0] lfsr_q;

// Contents of a word that was never written
function automatic logic [15:0] word_hash(input logic [21:0] a);
    logic [31:0] h;
    h = {10'd0, a} * 32'h9e37_79b9;
    return h[31:16];
endfunction

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [15:0] read_word(input int a);
    return mem.exists(a) ? mem[a] : word_hash(22'(a));
endfunction

// Delay of 0 to 3 cycles, two LFSR steps
task automatic pick_delay(output int d);
    d = 0;
    repeat (2) begin
        lfsr_q = lfsr_next(lfsr_q);
        d = (d << 1) | int'(lfsr_q[0]);
    end
endtask

initial begin
    int          a;
    int          dly;
    logic        wr;
    logic [15:0] d;
    logic [15:0] w;
    logic [ 1:0] m;
    ba_ack    = 1'b0;
    ba_dst    = 1'b0;
    ba_rdy    = 1'b0;
    data_read = 16'd0;
    lfsr_q    = 32'h6bc4_995f;
    forever begin
        @(posedge clk);
        if (sdram_rd || sdram_wr) begin
            a  = int'(sdram_addr);
            wr = sdram_wr;
            d  = data_write;
            m  = sdram_wrmask;
            pick_delay(dly);
            repeat (dly) @(posedge clk);
            ba_ack <= 1'b1;
            @(posedge clk);
            ba_ack <= 1'b0;
            pick_delay(dly);
            repeat (dly) @(posedge clk);
            ba_dst <= 1'b1;
            @(posedge clk);
            ba_dst <= 1'b0;
            if (wr) begin
                // Mask is active low, bit 1 for the upper byte
                w = read_word(a);
                if (!m[1]) w[15:8] = d[15:8];
                if (!m[0]) w[7:0] = d[7:0];
                mem[a] = w;
            end
            pick_delay(dly);
            repeat (dly) @(posedge clk);
            data_read <= read_word(a);
            ba_rdy    <= 1'b1;
            @(posedge clk);
            ba_rdy <= 1'b0;
        end
    end
end

endmodule

// ==== testbench/jtcop_sdram_tb.sv ====
`timescale 1ns/100ps

module jtcop_sdram_tb;

import jtcop_sdram_pkg::*;

localparam int timeout = 2000;

logic        clk;
logic        rst;
logic        ram_cs;
logic        main_cs;
logic [18:1] main_addr;
logic        main_rnw;
logic [15:0] main_dout;
logic [ 1:0] dsn;
logic [ 5:0] layer_sel;
logic        b0_cs;
logic [12:0] b0_addr;
logic        downloading;
logic [24:0] ioctl_addr;
logic [ 7:0] ioctl_dout;
logic        ioctl_wr;
logic [15:0] ram_data;
logic [15:0] main_data;
logic [15:0] b0_data;
logic        ram_ok;
logic        main_ok;
logic        b0_ok;
logic        dwnld_busy;
logic [21:0] sdram_addr;
logic        sdram_rd;
logic        sdram_wr;
logic [15:0] data_write;
logic [ 1:0] sdram_wrmask;
logic        ba_ack;
logic        ba_dst;
logic        ba_rdy;
logic [15:0] data_read;

logic [15:0] shadow [int];
logic [31:0] lfsr_q;
logic [17:0] rnd_words[$];
int          checks;
int          errors;

jtcop_sdram dut_i(
    .rst(rst), .clk(clk),
    .ram_cs(ram_cs), .main_cs(main_cs), .main_addr(main_addr), .main_rnw(main_rnw),
    .main_dout(main_dout), .dsn(dsn), .ram_data(ram_data), .ram_ok(ram_ok),
    .main_data(main_data), .main_ok(main_ok),
    .fsft_cs(layer_sel[0]), .fmap_cs(layer_sel[1]), .bsft_cs(layer_sel[2]),
    .bmap_cs(layer_sel[3]), .csft_cs(layer_sel[4]), .cmap_cs(layer_sel[5]),
    .b0_cs(b0_cs), .b0_addr(b0_addr), .b0_data(b0_data), .b0_ok(b0_ok),
    .sdram_addr(sdram_addr), .sdram_rd(sdram_rd), .sdram_wr(sdram_wr),
    .data_write(data_write), .sdram_wrmask(sdram_wrmask),
    .ba_ack(ba_ack), .ba_dst(ba_dst), .ba_rdy(ba_rdy), .data_read(data_read),
    .downloading(downloading), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
    .ioctl_wr(ioctl_wr), .dwnld_busy(dwnld_busy)
);

sdram_model mdl(
    .clk(clk), .sdram_addr(sdram_addr), .sdram_rd(sdram_rd), .sdram_wr(sdram_wr),
    .data_write(data_write), .sdram_wrmask(sdram_wrmask), .ba_ack(ba_ack),
    .ba_dst(ba_dst), .ba_rdy(ba_rdy), .data_read(data_read)
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

// Fibonacci LFSR stepped once for each bit
function logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = 32'd0;
    for (int i = 0; i < n; i++) begin
        lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
        v = {v[30:0], lfsr_q[0]};
    end
    return v;
endfunction

function automatic logic [15:0] word_hash(input logic [21:0] a);
    logic [31:0] h;
    h = {10'd0, a} * 32'h9e37_79b9;
    return h[31:16];
endfunction

// Expected SDRAM word at a bank address
function automatic logic [15:0] ref_word(input logic [21:0] sa);
    return shadow.exists(int'(sa)) ? shadow[int'(sa)] : word_hash(sa);
endfunction

// Tile layer windows inside the video RAM
function automatic logic [14:0] merged_addr(input logic [5:0] sel, input logic [12:0] a);
    if (sel[0]) return {3'b010, a[11:0]};
    if (sel[1]) return {3'b011, a[11:0]};
    if (sel[2]) return {5'b10000, a[9:0]};
    if (sel[3]) return {5'b10001, a[9:0]};
    if (sel[4]) return {5'b10010, a[9:0]};
    if (sel[5]) return {5'b10011, a[9:0]};
    return {2'b00, a};
endfunction

function automatic logic ok_of(input int sel);
    return sel == 0 ? ram_ok : (sel == 1 ? main_ok : b0_ok);
endfunction

task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("error %s expected %h actual %h", name, exp, act);
    end
endtask

task automatic wait_ok(input int sel, input string name);
    int n;
    n = 0;
    @(posedge clk);
    while (!ok_of(sel) && n < timeout) begin
        @(posedge clk);
        n++;
    end
    if (!ok_of(sel)) begin
        errors++;
        $display("timed out waiting for the %s to complete", name);
    end
endtask

task automatic rom_read(input logic [17:0] a);
    @(posedge clk);
    ram_cs    <= 1'b0;
    main_cs   <= 1'b1;
    main_rnw  <= 1'b1;
    main_addr <= a;
    wait_ok(1, "rom read");
    check("rom read", {16'd0, ref_word(rom_offset + {4'd0, a})}, {16'd0, main_data});
endtask

task automatic ram_read(input logic [12:0] a, input logic [5:0] sel);
    logic [21:0] sa;
    sa = ram_offset + {7'd0, merged_addr(sel, a)};
    @(posedge clk);
    main_cs   <= 1'b0;
    ram_cs    <= 1'b1;
    main_rnw  <= 1'b1;
    main_addr <= {5'd0, a};
    layer_sel <= sel;
    wait_ok(0, "ram read");
    check("ram read", {16'd0, ref_word(sa)}, {16'd0, ram_data});
endtask

task automatic ram_write(input logic [12:0] a, input logic [1:0] m, input logic [15:0] d,
                         input logic [5:0] sel);
    logic [21:0] sa;
    logic [15:0] w;
    sa = ram_offset + {7'd0, merged_addr(sel, a)};
    @(posedge clk);
    main_cs   <= 1'b0;
    ram_cs    <= 1'b1;
    main_rnw  <= 1'b0;
    main_addr <= {5'd0, a};
    main_dout <= d;
    dsn       <= m;
    layer_sel <= sel;
    wait_ok(0, "ram write");
    w = ref_word(sa);
    if (!m[1]) w[15:8] = d[15:8];
    if (!m[0]) w[7:0] = d[7:0];
    shadow[int'(sa)] = w;
endtask

task automatic b0_read(input logic [12:0] a);
    @(posedge clk);
    b0_cs   <= 1'b1;
    b0_addr <= a;
    wait_ok(2, "b0 read");
    check("b0 read", {16'd0, ref_word(ram_offset + b0_offset + {9'd0, a})}, {16'd0, b0_data});
endtask

task automatic download_byte(input logic [24:0] a, input logic [7:0] b);
    int          n;
    logic [15:0] w;
    @(posedge clk);
    ioctl_addr <= a;
    ioctl_dout <= b;
    ioctl_wr   <= 1'b1;
    @(posedge clk);
    ioctl_wr <= 1'b0;
    n = 0;
    @(posedge clk);
    while (dut_i.prog_we && n < timeout) begin
        @(posedge clk);
        n++;
    end
    if (dut_i.prog_we) begin
        errors++;
        $display("timed out waiting for a download write to complete");
    end
    if (a < ba1_start) begin
        // Even byte sits in the upper half
        w = ref_word(a[22:1]);
        if (a[0]) w[7:0] = b;
        else w[15:8] = b;
        shadow[int'(a[22:1])] = w;
    end
endtask

initial begin
    int          n;
    int          busy_cnt;
    logic [24:0] a;
    rst = 1'b1;
    ram_cs = 1'b0;
    main_cs = 1'b0;
    main_addr = 18'd0;
    main_rnw = 1'b1;
    main_dout = 16'd0;
    dsn = 2'b11;
    layer_sel = 6'd0;
    b0_cs = 1'b0;
    b0_addr = 13'd0;
    downloading = 1'b0;
    ioctl_addr = 25'd0;
    ioctl_dout = 8'd0;
    ioctl_wr = 1'b0;
    lfsr_q = 32'h6bc4_995f;
    checks = 0;
    errors = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check("reset levels", 32'd0,
          {26'd0, sdram_rd, sdram_wr, ram_ok, main_ok, b0_ok, dwnld_busy});

    // Cached ROM word that the download has to flush
    rom_read(18'h800);

    // ROM image download
    @(posedge clk);
    downloading <= 1'b1;
    for (int i = 0; i < 64; i++) begin
        download_byte(25'h1000 + 25'(i), 8'(rand_bits(8)));
    end
    for (int i = 0; i < 8; i++) begin
        a = 25'(rand_bits(19));
        rnd_words.push_back(a[18:1]);
        download_byte(a, 8'(rand_bits(8)));
    end
    // Bank 1 bytes must not reach bank 0
    download_byte(ba1_start, 8'h5a);
    check("bank 1 byte", {16'd0, word_hash(ba1_start[22:1])},
          {16'd0, mdl.read_word(int'(ba1_start[22:1]))});

    // Settle time with a ROM request pending
    @(posedge clk);
    downloading <= 1'b0;
    main_cs     <= 1'b1;
    main_rnw    <= 1'b1;
    main_addr   <= 18'h800;
    busy_cnt = 0;
    n = 0;
    @(posedge clk);
    while (dwnld_busy && n < timeout) begin
        busy_cnt++;
        if (ram_ok || main_ok || b0_ok) begin
            errors++;
            $display("a slot reported ok while the download was settling");
        end
        @(posedge clk);
        n++;
    end
    check("busy length", 32'(settle_cycles), 32'(busy_cnt));
    wait_ok(1, "rom read after settle");
    check("rom read", {16'd0, ref_word(22'h800)}, {16'd0, main_data});

    for (int i = 0; i < 32; i++) begin
        rom_read(18'h800 + 18'(i));
    end
    foreach (rnd_words[i]) begin
        rom_read(rnd_words[i]);
    end

    // Byte masked RAM writes
    for (int m = 0; m < 4; m++) begin
        ram_read(13'h0100 + 13'(m), 6'd0);
        ram_write(13'h0100 + 13'(m), 2'(m), 16'(rand_bits(16)), 6'd0);
        ram_read(13'h0100 + 13'(m), 6'd0);
    end
    ram_write(13'h0200, 2'b01, 16'hbeef, 6'd0);
    ram_read(13'h0200, 6'd0);

    // Tile layer windows
    for (int l = 0; l < 6; l++) begin
        ram_write(13'h0040 + 13'(l), 2'b00, 16'(rand_bits(16)), 6'(1 << l));
        ram_read(13'h0040 + 13'(l), 6'(1 << l));
        check("layer landing",
              {16'd0, ref_word(ram_offset + {7'd0, merged_addr(6'(1 << l), 13'h0040 + 13'(l))})},
              {16'd0, mdl.read_word(int'(ram_offset
                  + {7'd0, merged_addr(6'(1 << l), 13'h0040 + 13'(l))}))});
    end
    b0_read(13'h0040);
    b0_read(13'h1041);

    // Hit after cs returns and a miss on an address change
    rom_read(18'h805);
    @(posedge clk);
    main_cs <= 1'b0;
    @(posedge clk);
    main_cs <= 1'b1;
    @(posedge clk);
    if (main_ok) begin
        errors++;
        $display("a repeated ROM read reported ok in the same cycle as cs");
    end
    @(posedge clk);
    if (!main_ok) begin
        errors++;
        $display("a repeated ROM read did not hit one cycle after cs");
    end
    check("rom hit", {16'd0, ref_word(22'h805)}, {16'd0, main_data});
    @(posedge clk);
    main_addr <= 18'h806;
    @(posedge clk);
    if (main_ok) begin
        errors++;
        $display("ok stayed high after the ROM address changed");
    end
    wait_ok(1, "rom read after address change");
    check("rom miss", {16'd0, ref_word(22'h806)}, {16'd0, main_data});

    // CPU and B0 traffic together
    fork
        begin
            for (int i = 0; i < 40; i++) begin
                case (rand_bits(2))
                    32'd0: rom_read(18'(rand_bits(18)));
                    32'd1: begin
                        a = 25'(rand_bits(13));
                        ram_write(a[12:0], 2'(rand_bits(2)), 16'(rand_bits(16)), 6'd0);
                        ram_read(a[12:0], 6'd0);
                    end
                    default: ram_read(13'(rand_bits(13)), 6'd0);
                endcase
            end
        end
        begin
            for (int i = 0; i < 40; i++) begin
                b0_read(13'(rand_bits(13)));
            end
        end
    join

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
        $display("Verification passed");
    end else begin
        $display("Verification failed");
    end
    $finish;
end

endmodule

// ==== jtcop_sdram.f ====
src/jtcop_sdram_pkg.sv
src/jtcop_vram_map.sv
src/jtcop_slot_cache.sv
src/jtcop_bank_fsm.sv
src/jtcop_dwnld.sv
src/jtcop_busy_timer.sv
src/jtcop_sdram.sv
testbench/sdram_model.sv
testbench/jtcop_sdram_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module jtcop_sdram_tb -f jtcop_sdram.f -o jtcop_sdram_sim
out=$(./obj_dir/jtcop_sdram_sim)
echo "$out"
echo "$out" | grep -qx "Verification passed"
